// File: logic/sound_pkg.sv
package sound_pkg;

	localparam int NOTE_W = 6;   // notes 0..63, six octaves of twelve
	localparam int PERIOD_W = 20; // half-period count in clk50mhz cycles

	// effect select codes
	localparam logic [1:0] FX_NONE = 2'd0;
	localparam logic [1:0] FX_PORTA = 2'd1;
	localparam logic [1:0] FX_VIBRATO = 2'd2;
	localparam logic [1:0] FX_RESERVED = 2'd3; // same as FX_NONE

	// half-periods of the lowest octave at 50 MHz, C upward
	// higher octaves are these shifted right by note div 12
	localparam logic [0:11][PERIOD_W-1:0] SEMITONE_PERIOD = '{
		20'd764451, // c
		20'd721546, // c#
		20'd681048, // d
		20'd642824, // d#
		20'd606746, // e
		20'd572692, // f
		20'd540549, // f#
		20'd510210, // g
		20'd481574, // g#
		20'd454545, // a
		20'd429033, // a#
		20'd404954  // b
	};

	// one option nibble, read differently by each effect
	typedef union packed {
		logic [3:0] porta_interval; // ticks per semitone step, minus one
		struct packed {
			logic [1:0] speed; // ticks per phase step, minus one
			logic [1:0] depth; // peak multiplier, minus one
		} vib;
	} fx_opt_u;

endpackage

// File: logic/note_period_gen.sv
module note_period_gen #(
	parameter int unsigned PERIOD_SHIFT = 0
) (
	input  logic                           clk50mhz,
	input  logic                           rst_n,
	input  logic [sound_pkg::NOTE_W-1:0]   note,
	input  logic [2:0]                     offset_mul,
	input  logic                           offset_dir,
	output logic [sound_pkg::PERIOD_W-1:0] period
);

	localparam int PW = sound_pkg::PERIOD_W;
	localparam logic [PW-1:0] PERIOD_MIN = 2; // shortest half-period allowed

	logic [3:0]    semitone; // note mod 12
	logic [2:0]    octave;   // note div 12, 0..5
	logic [PW-1:0] base;     // unbent half-period
	logic [PW-1:0] step;     // one vibrato unit, base/64
	logic [PW-1:0] adj;      // total vibrato bend
	logic [PW-1:0] bent;
	logic [PW-1:0] scaled;   // after prescale
	logic [PW-1:0] period_d;

	always_comb
	begin
		semitone = 4'(note % 12);
		octave = 3'(note / 12);
		base = sound_pkg::SEMITONE_PERIOD[semitone] >> octave;
		step = base >> 6;
		adj = step * PW'(offset_mul); // max 4*11944, no overflow
		// dir set means shorter period, so pitch goes up
		bent = offset_dir ? (base - adj) : (base + adj);
		scaled = bent >> PERIOD_SHIFT;
		period_d = (scaled < PERIOD_MIN) ? PERIOD_MIN : scaled; // floor
	end

	always_ff @(posedge clk50mhz)
	begin
		if (!rst_n)
			period <= PERIOD_MIN;
		else
			period <= period_d; // one cycle behind note/offset
	end

	// square_gen relies on a count of at least two
	period_floor_a: assert property (
		@(posedge clk50mhz) disable iff (!rst_n)
		period >= PERIOD_MIN
	);

endmodule

// File: logic/fx_portamento.sv
module fx_portamento (
	input  logic                         clk50mhz,
	input  logic                         rst_n,
	input  logic                         en,
	input  logic [sound_pkg::NOTE_W-1:0] target,
	input  logic [3:0]                   interval,
	input  logic                         note_tick,
	output logic [sound_pkg::NOTE_W-1:0] note_out
);

	logic [3:0] tick_cnt; // ticks since last semitone step
	logic       step_now;  // interval expired on this tick

	assign step_now = note_tick && (tick_cnt >= interval);

	always_ff @(posedge clk50mhz)
	begin
		if (!rst_n)
		begin
			note_out <= '0;
			tick_cnt <= '0;
		end
		else if (!en)
		begin
			// glide starts from whatever was sounding last
			note_out <= target;
			tick_cnt <= '0;
		end
		else if (note_tick)
		begin
			if (step_now)
			begin
				tick_cnt <= '0;
				if (note_out < target)
					note_out <= note_out + 1'b1; // glide up
				else if (note_out > target)
					note_out <= note_out - 1'b1; // glide down
			end
			else
			begin
				tick_cnt <= tick_cnt + 1'b1;
			end
		end
	end

	// one semitone at a time, never a jump while gliding
	porta_step_a: assert property (
		@(posedge clk50mhz) disable iff (!rst_n)
		$past(rst_n) && $past(en) |->
			(note_out == $past(note_out)) ||
			(note_out == $past(note_out) + 1'b1) ||
			(note_out == $past(note_out) - 1'b1)
	);

endmodule

// File: logic/fx_vibrato.sv
module fx_vibrato (
	input  logic       clk50mhz,
	input  logic       rst_n,
	input  logic       en,
	input  logic [1:0] speed,
	input  logic [1:0] depth,
	input  logic       note_tick,
	output logic [2:0] offset_mul,
	output logic       offset_dir
);

	logic [1:0] tick_cnt;  // ticks since last phase step
	logic       falling;   // on the way back to zero
	logic [2:0] peak;      // depth+1, so 1..4
	logic       phase_step;

	assign peak = {1'b0, depth} + 3'd1;
	assign phase_step = note_tick && (tick_cnt >= speed);

	always_ff @(posedge clk50mhz)
	begin
		if (!rst_n || !en)
		begin
			tick_cnt <= '0;
			falling <= 1'b0;
			offset_mul <= '0;
			offset_dir <= 1'b0;
		end
		else if (note_tick)
		begin
			if (!phase_step)
			begin
				tick_cnt <= tick_cnt + 1'b1;
			end
			else
			begin
				tick_cnt <= '0;
				if (!falling)
				begin
					// >= so a smaller new depth still turns around
					if (offset_mul >= peak)
					begin
						falling <= 1'b1;
						offset_mul <= offset_mul - 1'b1;
					end
					else
					begin
						offset_mul <= offset_mul + 1'b1;
					end
				end
				else if (offset_mul == '0)
				begin
					// back at center, swing to the other side
					falling <= 1'b0;
					offset_dir <= ~offset_dir;
					offset_mul <= 3'd1;
				end
				else
				begin
					offset_mul <= offset_mul - 1'b1;
				end
			end
		end
	end

	// note_period_gen sizes its bend for at most 4 units
	vib_depth_a: assert property (
		@(posedge clk50mhz) disable iff (!rst_n)
		offset_mul <= 3'd4
	);

endmodule

// File: logic/square_gen.sv
module square_gen (
	input  logic                           clk50mhz,
	input  logic                           rst_n,
	input  logic                           en,
	input  logic [3:0]                     volume,
	input  logic [sound_pkg::PERIOD_W-1:0] period,
	output logic [3:0]                     wave_out
);

	logic [sound_pkg::PERIOD_W-1:0] cnt; // cycles left in this half
	logic                           phase; // high or low half
	logic                           expire;

	// toggle on the last cycle, so each half lasts exactly period cycles
	assign expire = (cnt <= 1);

	always_ff @(posedge clk50mhz)
	begin
		if (!rst_n || !en)
		begin
			cnt <= '0;
			phase <= 1'b0;
		end
		else if (expire)
		begin
			cnt <= period; // new pitch only lands here
			phase <= ~phase;
		end
		else
		begin
			cnt <= cnt - 1'b1;
		end
	end

	// sample level, zero in low half or when muted
	always_comb
	begin
		if (en && phase)
			wave_out = volume;
		else
			wave_out = 4'd0;
	end

endmodule

// File: logic/sq_channel.sv
module sq_channel #(
	parameter int unsigned PERIOD_SHIFT = 0
) (
	input  logic                         clk50mhz,
	input  logic                         rst_n,
	input  logic                         req,
	output logic                         ack,
	input  logic [sound_pkg::NOTE_W-1:0] note,
	input  logic [1:0]                   fx_sel,
	input  sound_pkg::fx_opt_u           fx_opt,
	input  logic [3:0]                   volume,
	input  logic                         channel_en,
	input  logic                         note_tick,
	output logic [3:0]                   wave_out
);

	logic [sound_pkg::NOTE_W-1:0]   target_q;   // latched note
	sound_pkg::fx_opt_u             fx_opt_q;
	logic [3:0]                     volume_q;
	logic                           chan_en_q;
	logic                           porta_en;
	logic                           vibrato_en;

	logic [sound_pkg::NOTE_W-1:0]   porta_note;
	logic [2:0]                     vib_mul;
	logic                           vib_dir;
	logic [sound_pkg::NOTE_W-1:0]   sound_note; // note fed to period gen
	logic [2:0]                     sel_mul;
	logic                           sel_dir;
	logic [sound_pkg::PERIOD_W-1:0] period;

	// four-phase req/ack, latch on req seen with ack low
	always_ff @(posedge clk50mhz)
	begin
		if (!rst_n)
		begin
			ack <= 1'b0;
			target_q <= '0;
			fx_opt_q <= '0;
			volume_q <= '0;
			chan_en_q <= 1'b0;
			porta_en <= 1'b0;
			vibrato_en <= 1'b0;
		end
		else if (req && !ack)
		begin
			ack <= 1'b1;
			target_q <= note;
			fx_opt_q <= fx_opt;
			volume_q <= volume;
			chan_en_q <= channel_en;
			// enables change together with the target, so a glide
			// starts from the old note
			case (fx_sel)
				sound_pkg::FX_PORTA:
				begin
					porta_en <= 1'b1;
					vibrato_en <= 1'b0;
				end
				sound_pkg::FX_VIBRATO:
				begin
					porta_en <= 1'b0;
					vibrato_en <= 1'b1;
				end
				sound_pkg::FX_NONE, sound_pkg::FX_RESERVED:
				begin
					porta_en <= 1'b0;
					vibrato_en <= 1'b0;
				end
				default:
				begin
					porta_en <= 1'b0;
					vibrato_en <= 1'b0;
				end
			endcase
		end
		else if (!req && ack)
		begin
			ack <= 1'b0; // host released, ready for next command
		end
	end

	// effect muxes
	assign sound_note = porta_en ? porta_note : target_q;
	assign sel_mul = vibrato_en ? vib_mul : 3'd0;
	assign sel_dir = vibrato_en ? vib_dir : 1'b0;

	fx_portamento porta_i (
		.clk50mhz  (clk50mhz),
		.rst_n     (rst_n),
		.en        (porta_en),
		.target    (target_q),
		.interval  (fx_opt_q.porta_interval),
		.note_tick (note_tick),
		.note_out  (porta_note)
	);

	fx_vibrato vibrato_i (
		.clk50mhz   (clk50mhz),
		.rst_n      (rst_n),
		.en         (vibrato_en),
		.speed      (fx_opt_q.vib.speed),
		.depth      (fx_opt_q.vib.depth),
		.note_tick  (note_tick),
		.offset_mul (vib_mul),
		.offset_dir (vib_dir)
	);

	note_period_gen #(
		.PERIOD_SHIFT (PERIOD_SHIFT)
	) period_i (
		.clk50mhz   (clk50mhz),
		.rst_n      (rst_n),
		.note       (sound_note),
		.offset_mul (sel_mul),
		.offset_dir (sel_dir),
		.period     (period)
	);

	square_gen square_i (
		.clk50mhz (clk50mhz),
		.rst_n    (rst_n),
		.en       (chan_en_q),
		.volume   (volume_q),
		.period   (period),
		.wave_out (wave_out)
	);

	// ack only answers a request that was actually there
	ack_needs_req_a: assert property (
		@(posedge clk50mhz) disable iff (!rst_n)
		$rose(ack) |-> $past(req)
	);

endmodule

// File: bench/sq_channel_tb.sv
module sq_channel_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int unsigned PERIOD_SHIFT = 6; // short periods for simulation
	localparam int TICK_CYCLES = 64;
	localparam int RAND_CMDS = 6;     // random notes per effect code
	localparam int CHECK_HALVES = 4;
	localparam int VIB_NOTE = 63;     // shortest periods, best odds to catch a peak
	localparam int VIB_CYCLES = 12;   // triangle cycles allowed to reach both extremes
	localparam int GLIDE_HALVES = 24;
	localparam int VIB_HALVES = 120;
	localparam int PLANNED_HALVES = 2 * RAND_CMDS * (CHECK_HALVES + 2) + 4
		+ 2 * GLIDE_HALVES + 4 * VIB_HALVES;

	logic clk50mhz = 1'b0;
	logic rst_n = 1'b0;
	logic req = 1'b0;
	logic ack;
	logic [sound_pkg::NOTE_W-1:0] note = '0;
	logic [1:0] fx_sel = sound_pkg::FX_NONE;
	sound_pkg::fx_opt_u fx_opt = '0;
	logic [3:0] volume = '0;
	logic channel_en = 1'b0;
	logic note_tick = 1'b0;
	logic [3:0] wave_out;

	int seed = 32'hc4230383;
	logic [5:0] tick_div = '0;
	int cycle_no = 0;
	int half_limit = 0; // longest half plus slack

	// monitor state
	logic prev_hi = 1'b0;
	logic [3:0] hi_level = '0;   // wave_out one sample ago
	int run_len = 0;
	int half_count = 0;
	int last_half = 0;           // cycles in the last finished half
	logic last_was_high = 1'b0;
	logic [3:0] last_level = '0;

	sq_channel #(
		.PERIOD_SHIFT (PERIOD_SHIFT)
	) dut_i (
		.clk50mhz   (clk50mhz),
		.rst_n      (rst_n),
		.req        (req),
		.ack        (ack),
		.note       (note),
		.fx_sel     (fx_sel),
		.fx_opt     (fx_opt),
		.volume     (volume),
		.channel_en (channel_en),
		.note_tick  (note_tick),
		.wave_out   (wave_out)
	);

	always #10 clk50mhz = ~clk50mhz; // 50 MHz

	always @(posedge clk50mhz)
	begin
		tick_div <= tick_div + 6'd1;
		note_tick <= (tick_div == 6'd63); // one frame tick every 64 cycles
		cycle_no <= cycle_no + 1;
	end

	// half-period meter, counts samples between level changes
	always @(negedge clk50mhz)
	begin
		hi_level <= wave_out;
		if (!rst_n)
		begin
			prev_hi <= 1'b0;
			run_len <= 0;
			half_count <= 0;
		end
		else if ((wave_out != 4'd0) != prev_hi)
		begin
			last_half <= run_len;
			last_was_high <= prev_hi;
			last_level <= hi_level; // last sample of the finished half
			half_count <= half_count + 1;
			prev_hi <= (wave_out != 4'd0);
			run_len <= 1;
		end
		else
			run_len <= run_len + 1;
	end

	// base from the semitone table, octave shift, bend, prescale, floor
	function automatic int expected_half_period(input int n, input int mul, input bit dir);
		logic [3:0] semi;
		int base;
		int bend;
		int half;
		semi = 4'(n % 12);
		base = int'(sound_pkg::SEMITONE_PERIOD[semi]) >> (n / 12);
		bend = mul * (base >> 6);
		half = dir ? (base - bend) : (base + bend); // dir set raises pitch
		half = half >> PERIOD_SHIFT;
		if (half < 2)
			half = 2;
		return half;
	endfunction

	task automatic abort_run(input string reason);
		if (reason != "")
			$display("%s", reason);
		$display("Verification failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input int got, input int expected);
		if (got != expected)
		begin
			$display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, expected);
			abort_run("");
		end
	endtask

	// blocks until the monitor closes another half
	task automatic wait_half(input int limit);
		int start_count;
		int waited;
		start_count = half_count;
		waited = 0;
		while (half_count == start_count)
		begin
			@(negedge clk50mhz);
			waited++;
			if (waited > limit)
				abort_run($sformatf("wave_out did not toggle within %0d cycles", limit));
		end
	endtask

	task automatic skip_halves(input int count);
		repeat (count) wait_half(half_limit);
	endtask

	// four-phase command, ack timing checked on every edge
	task automatic send_command(input logic [5:0] n, input logic [1:0] sel,
			input sound_pkg::fx_opt_u opt, input logic [3:0] vol, input logic en);
		@(posedge clk50mhz);
		note <= n;
		fx_sel <= sel;
		fx_opt <= opt;
		volume <= vol;
		channel_en <= en;
		req <= 1'b1;
		@(negedge clk50mhz);
		check_value("ack", int'(ack), 0); // req not yet seen
		@(negedge clk50mhz);
		check_value("ack", int'(ack), 1);
		@(posedge clk50mhz);
		req <= 1'b0;
		@(negedge clk50mhz);
		check_value("ack", int'(ack), 1); // drop not yet seen
		@(negedge clk50mhz);
		check_value("ack", int'(ack), 0);
	endtask

	task automatic play_plain_notes(input logic [1:0] sel);
		sound_pkg::fx_opt_u opt;
		logic [5:0] n;
		logic [3:0] vol;
		int expect_half;
		opt = '0;
		for (int i = 0; i < RAND_CMDS; i++)
		begin
			n = 6'(24 + ($unsigned($random(seed)) % 40)); // upper octaves keep runs short
			vol = 4'(1 + ($unsigned($random(seed)) % 15)); // nonzero so halves are visible
			send_command(n, sel, opt, vol, 1'b1);
			skip_halves(2); // old pitch finishes first
			expect_half = expected_half_period(int'(n), 0, 1'b0);
			for (int k = 0; k < CHECK_HALVES; k++)
			begin
				wait_half(half_limit);
				check_value("wave_out half-period", last_half, expect_half);
				if (last_was_high)
					check_value("wave_out level", int'(last_level), int'(vol));
			end
		end
	endtask

	task automatic check_mute(input logic [5:0] n);
		sound_pkg::fx_opt_u opt;
		int full;
		opt = '0;
		full = 2 * expected_half_period(int'(n), 0, 1'b0);
		send_command(n, sound_pkg::FX_NONE, opt, 4'd9, 1'b0);
		repeat (full)
		begin
			@(negedge clk50mhz);
			check_value("wave_out", int'(wave_out), 0);
		end
	endtask

	task automatic glide_between(input logic [5:0] from_n, input logic [5:0] to_n,
			input logic [3:0] interval);
		sound_pkg::fx_opt_u opt;
		int lo;
		int hi;
		int deadline;
		int prev_half;
		bit in_range;
		opt = '0;
		send_command(from_n, sound_pkg::FX_NONE, opt, 4'd12, 1'b1);
		skip_halves(2);
		wait_half(half_limit);
		check_value("wave_out half-period", last_half,
			expected_half_period(int'(from_n), 0, 1'b0));
		prev_half = last_half;
		lo = (from_n < to_n) ? int'(from_n) : int'(to_n);
		hi = (from_n < to_n) ? int'(to_n) : int'(from_n);
		opt.porta_interval = interval;
		send_command(to_n, sound_pkg::FX_PORTA, opt, 4'd12, 1'b1);
		deadline = cycle_no + ((hi - lo) * (int'(interval) + 1) + 2) * TICK_CYCLES;
		while (cycle_no < deadline)
		begin
			wait_half(half_limit);
			in_range = 1'b0;
			for (int m = lo; m <= hi; m++)
				if (last_half == expected_half_period(m, 0, 1'b0))
					in_range = 1'b1;
			if (!in_range)
				abort_run($sformatf("glide half-period 0x%0h fits no note from %0d to %0d",
					last_half, lo, hi));
			// higher note, shorter half
			if ((to_n > from_n && last_half > prev_half) ||
				(to_n < from_n && last_half < prev_half))
				abort_run($sformatf("glide turned back, half-period 0x%0h after 0x%0h",
					last_half, prev_half));
			prev_half = last_half;
		end
		skip_halves(1); // half running at the deadline
		wait_half(half_limit);
		check_value("wave_out half-period", last_half, expected_half_period(int'(to_n), 0, 1'b0));
	endtask

	task automatic sweep_vibrato(input logic [1:0] depth);
		sound_pkg::fx_opt_u opt;
		int peak;
		int lo_half;
		int hi_half;
		int tri_len;
		int start;
		bit seen_lo;
		bit seen_hi;
		opt = '0;
		opt.vib.speed = 2'd3; // four ticks per step, longest dwell at the peak
		opt.vib.depth = depth;
		peak = int'(depth) + 1;
		lo_half = expected_half_period(VIB_NOTE, peak, 1'b1);
		hi_half = expected_half_period(VIB_NOTE, peak, 1'b0);
		tri_len = 4 * peak * 4 * TICK_CYCLES; // four legs of peak steps
		send_command(6'(VIB_NOTE), sound_pkg::FX_VIBRATO, opt, 4'd7, 1'b1);
		skip_halves(2);
		start = cycle_no;
		seen_lo = 1'b0;
		seen_hi = 1'b0;
		while (!(seen_lo && seen_hi) || (cycle_no - start) < tri_len)
		begin
			if ((cycle_no - start) > VIB_CYCLES * tri_len)
				abort_run($sformatf("vibrato depth %0d never reached both extremes", peak));
			wait_half(half_limit);
			if (last_half < lo_half || last_half > hi_half)
				abort_run($sformatf("vibrato half-period 0x%0h outside 0x%0h to 0x%0h",
					last_half, lo_half, hi_half));
			if (last_half == lo_half)
				seen_lo = 1'b1;
			if (last_half == hi_half)
				seen_hi = 1'b1;
		end
	endtask

	initial
	begin
		half_limit = expected_half_period(0, 4, 1'b0) + 16;
		repeat (4) @(posedge clk50mhz);
		rst_n <= 1'b1;
		@(negedge clk50mhz);
		check_value("ack", int'(ack), 0);
		check_value("wave_out", int'(wave_out), 0);
		play_plain_notes(sound_pkg::FX_NONE);
		play_plain_notes(sound_pkg::FX_RESERVED);
		check_mute(6'd45);
		glide_between(6'd30, 6'd42, 4'd1); // upward
		glide_between(6'd50, 6'd41, 4'd2);
		for (int d = 0; d < 4; d++)
			sweep_vibrato(2'(d));
		$display("Verification passed");
		$finish;
	end

	// bound from the planned halves at the longest possible half
	initial
	begin
		int limit;
		limit = PLANNED_HALVES * expected_half_period(0, 4, 1'b0) + 20000;
		repeat (limit) @(posedge clk50mhz);
		abort_run($sformatf("watchdog expired after %0d cycles", limit));
	end

endmodule

// File: project.f
logic/sound_pkg.sv
logic/note_period_gen.sv
logic/fx_portamento.sv
logic/fx_vibrato.sv
logic/square_gen.sv
logic/sq_channel.sv
bench/sq_channel_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the square channel testbench with Verilator and run it into sim.log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
BIN=sq_channel_sim

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module sq_channel_tb -f project.f \
	--Mdir "$BUILD_DIR" -o "$BIN"
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$BUILD_DIR/$BIN" > "$LOG" 2>&1
run_status=$?

# the log decides, the exit status only backs it up
if grep -q "Verification failed" "$LOG"; then
	echo "simulation failed, see $LOG"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status, see $LOG"
	exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
	echo "simulation ended without a result, see $LOG"
	exit 1
fi
echo "simulation passed"
exit 0
